/* Makefile */
# Verilator build and run of the pattern streamer testbench

VERILATOR ?= verilator
TOP       ?= simframe_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the run prints the pass line
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

/* dv/simframe_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module simframe_tb;

   localparam int pattern_width = 32;
   localparam int fifo_depth    = 64;
   // Cycles any single wait may take before the run is abandoned
   localparam int wait_limit    = 200;
   localparam int max_words     = 16;

   logic                                     clk;
   logic                                     resetn;
   logic                                     reg_write;
   logic                                     reg_read;
   logic [simframe_pkg::reg_index_width-1:0] reg_windx;
   logic [simframe_pkg::reg_index_width-1:0] reg_rindx;
   logic [simframe_pkg::word_width-1:0]      reg_wdata;
   logic [1:0]                               reg_wresp;
   logic                                     wr_idle;
   logic                                     reg_rvalid;
   logic [simframe_pkg::word_width-1:0]      reg_rdata;
   logic [1:0]                               reg_rresp;
   logic [pattern_width-1:0]                 stream_data;
   logic                                     stream_valid;
   logic                                     stream_ready;
   logic                                     new_job;

   // Scoreboard state
   logic [31:0] expected_words [max_words];
   logic [31:0] lfsr_state;
   int          error_count;
   int          check_count;
   int          timeout_count;
   int          new_job_seen;
   int          new_job_mark;

   simframe_top #(
      .pattern_width (pattern_width),
      .fifo_depth    (fifo_depth)
   ) u_dut (
      .clk          (clk),
      .resetn       (resetn),
      .reg_write    (reg_write),
      .reg_read     (reg_read),
      .reg_windx    (reg_windx),
      .reg_rindx    (reg_rindx),
      .reg_wdata    (reg_wdata),
      .reg_wresp    (reg_wresp),
      .wr_idle      (wr_idle),
      .reg_rvalid   (reg_rvalid),
      .reg_rdata    (reg_rdata),
      .reg_rresp    (reg_rresp),
      .stream_data  (stream_data),
      .stream_valid (stream_valid),
      .stream_ready (stream_ready),
      .new_job      (new_job)
   );

   // 20 ns clock
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Count new_job pulses at the clock edge that ends them
   always @(posedge clk) begin
      if (!resetn) new_job_seen <= 0;
      else if (new_job) new_job_seen <= new_job_seen + 1;
   end

   // ========================================================================
   // Stall source and reporting
   // ========================================================================
   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] state);
      if (state[0]) return (state >> 1) ^ 32'h8020_0003;
      return state >> 1;
   endfunction

   // One LFSR step per bit taken
   task automatic random_bit(output logic bit_out);
      bit_out    = lfsr_state[0];
      lfsr_state = next_lfsr(lfsr_state);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      assert (actual === expected) else begin
         error_count++;
         $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic finish_run();
      $display("Summary: %0d checks, %0d errors, %0d timeouts",
               check_count, error_count, timeout_count);
      if ((error_count == 0) && (timeout_count == 0)) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   // Ends the trace early, the summary follows
   task automatic fail_timeout(input string what);
      timeout_count++;
      $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, wait_limit);
   endtask

   task automatic require_fields(input int got, input int want);
      if (got != want) begin
         error_count++;
         $display("Trace line read at %0t has %0d fields where %0d were expected",
                  $time, got, want);
      end
   endtask

   // ========================================================================
   // Register and stream operations entered on a falling edge
   // ========================================================================
   task automatic wait_write_idle();
      int cycles;
      cycles = 0;
      while (!wr_idle && (cycles < wait_limit)) begin
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic write_register(input logic [simframe_pkg::reg_index_width-1:0] idx,
                                 input logic [31:0] data, input logic [1:0] exp_resp);
      // Strobe only while the write side is idle
      wait_write_idle();
      if (!wr_idle) begin
         fail_timeout("wr_idle before a register write");
      end else begin
         reg_write = 1'b1;
         reg_windx = idx;
         reg_wdata = data;
         @(posedge clk);
         @(negedge clk);
         reg_write = 1'b0;
         check_value("reg_wresp", 32'(exp_resp), 32'(reg_wresp));
      end
   endtask

   task automatic read_register(input logic [simframe_pkg::reg_index_width-1:0] idx,
                                input logic [31:0] exp_data, input logic [1:0] exp_resp);
      reg_read  = 1'b1;
      reg_rindx = idx;
      @(posedge clk);
      @(negedge clk);
      reg_read = 1'b0;
      // Response lands exactly one cycle after the strobe
      check_value("reg_rvalid", 32'd1, 32'(reg_rvalid));
      check_value("reg_rdata", exp_data, reg_rdata);
      check_value("reg_rresp", 32'(exp_resp), 32'(reg_rresp));
   endtask

   task automatic expect_stream(input int n, input logic end_flag);
      int   got;
      int   idle;
      logic ready_bit;
      got  = 0;
      idle = 0;
      while ((got < n) && (idle < wait_limit)) begin
         random_bit(ready_bit);
         stream_ready = ready_bit;
         // Valid and data are stable here
         // Transfer happens on the next rising edge
         if (stream_valid && stream_ready) begin
            check_value("stream_data", expected_words[got], 32'(stream_data));
            got++;
            idle = 0;
         end else begin
            idle++;
         end
         @(posedge clk);
         @(negedge clk);
      end
      stream_ready = 1'b0;
      if (got < n) begin
         fail_timeout("stream transfer");
      end else begin
         // Valid drops at the end of a pass and stays high in continuous replay
         check_value("stream_valid", 32'(!end_flag), 32'(stream_valid));
      end
   endtask

   task automatic expect_quiet(input int cycles);
      int i;
      stream_ready = 1'b1;
      for (i = 0; i < cycles; i++) begin
         check_value("stream_valid", 32'd0, 32'(stream_valid));
         @(posedge clk);
         @(negedge clk);
      end
      stream_ready = 1'b0;
   endtask

   task automatic expect_new_jobs(input int n);
      check_value("new_job pulses", 32'(n), 32'(new_job_seen - new_job_mark));
      new_job_mark = new_job_seen;
   endtask

   // ========================================================================
   // Trace player
   // ========================================================================
   task automatic run_trace();
      int               fd;
      int               code;
      int               n;
      int               i;
      logic [7:0]       op;
      logic [8*160-1:0] rest;
      logic [31:0]      idx;
      logic [31:0]      data;
      logic [31:0]      resp;
      fd = $fopen("dv/simframe_trace.txt", "r");
      if (fd == 0) begin
         error_count++;
         $display("Could not open the trace file dv/simframe_trace.txt");
      end else begin
         op = '0;
         while ((timeout_count == 0) && ($fscanf(fd, "%s", op) == 1)) begin
            case (op)
               "#": code = $fgets(rest, fd);
               "W": begin
                  code = $fscanf(fd, "%h %h %h", idx, data, resp);
                  require_fields(code, 3);
                  write_register(idx[simframe_pkg::reg_index_width-1:0], data, resp[1:0]);
               end
               "R": begin
                  code = $fscanf(fd, "%h %h %h", idx, data, resp);
                  require_fields(code, 3);
                  read_register(idx[simframe_pkg::reg_index_width-1:0], data, resp[1:0]);
               end
               "S": begin
                  code = $fscanf(fd, "%d", n);
                  require_fields(code, 1);
                  if (n > max_words) n = max_words;
                  for (i = 0; i < n; i++) begin
                     code = $fscanf(fd, "%h", data);
                     require_fields(code, 1);
                     expected_words[i] = data;
                  end
                  code = $fscanf(fd, "%h", resp);
                  require_fields(code, 1);
                  expect_stream(n, resp[0]);
               end
               "J": begin
                  code = $fscanf(fd, "%d", n);
                  require_fields(code, 1);
                  expect_new_jobs(n);
               end
               "L": begin
                  code = $fscanf(fd, "%h", data);
                  require_fields(code, 1);
                  check_value("wr_idle", data, 32'(wr_idle));
               end
               "I": begin
                  wait_write_idle();
                  if (!wr_idle) fail_timeout("wr_idle after a clear");
               end
               "Q": begin
                  code = $fscanf(fd, "%d", n);
                  require_fields(code, 1);
                  expect_quiet(n);
               end
               default: begin
                  error_count++;
                  $display("Unknown operation %s in the trace file", op);
               end
            endcase
            op = '0;
         end
         $fclose(fd);
      end
   endtask

   initial begin
      resetn        = 1'b0;
      reg_write     = 1'b0;
      reg_read      = 1'b0;
      reg_windx     = '0;
      reg_rindx     = '0;
      reg_wdata     = '0;
      stream_ready  = 1'b0;
      lfsr_state    = 32'hf296;
      error_count   = 0;
      check_count   = 0;
      timeout_count = 0;
      new_job_mark  = 0;
      // Reset held for 10 cycles and released on a falling edge
      repeat (10) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
      check_value("stream_valid", 32'd0, 32'(stream_valid));
      check_value("new_job", 32'd0, 32'(new_job));
      check_value("reg_rvalid", 32'd0, 32'(reg_rvalid));
      check_value("wr_idle", 32'd1, 32'(wr_idle));
      run_trace();
      finish_run();
   end

endmodule

`default_nettype wire

/* dv/simframe_trace.txt */
# Indices, data, responses and levels in hex, word and cycle counts in decimal
# W indx data resp | R indx data resp | S count words end | J pulses | L wr_idle | I | Q cycles
# Version register, decode errors and empty counts after reset
R 0 00000001 0
R 6 00000000 3
W 6 12345678 3
R 2 00000000 0
R 3 00000000 0
# One-shot pass of FIFO 0
W 2 a5a50001 0
W 2 5a5a0002 0
W 2 c3c30003 0
R 2 00000003 0
W 4 00000001 0
S 3 a5a50001 5a5a0002 c3c30003 1
J 1
R 4 00000000 0
# Replay from the written-back words
W 4 00000001 0
S 3 a5a50001 5a5a0002 c3c30003 1
J 1
R 2 00000003 0
# Continuous replay of FIFO 1 over three passes
W 5 00000001 0
W 3 11110000 0
W 3 2222ffff 0
R 3 00000002 0
W 4 00000002 0
S 6 11110000 2222ffff 11110000 2222ffff 11110000 2222ffff 0
J 1
R 4 00000002 0
W 3 33333333 0
R 3 00000002 0
R 5 00000001 0
W 4 00000000 0
S 2 11110000 2222ffff 1
R 4 00000000 0
W 5 00000000 0
# Clear of idle FIFO 0, then a refused start
W 1 00000001 0
L 0
R 1 00000001 0
I
L 1
R 1 00000000 0
R 2 00000000 0
W 4 00000001 0
R 4 00000000 0
Q 40
J 0

/* source/pattern_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module pattern_fifo #(
   parameter int pattern_width = 32,
   parameter int fifo_depth    = 64,
   localparam int count_width  = $clog2(fifo_depth + 1),
   localparam int addr_width   = $clog2(fifo_depth)
) (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     clear,
   input  logic                     load,
   input  logic [pattern_width-1:0] load_data,
   input  logic                     pop,
   output logic [pattern_width-1:0] head_data,
   output logic                     head_valid
);

   localparam logic [addr_width-1:0] last_addr = addr_width'(fifo_depth - 1);

   logic [pattern_width-1:0] mem [fifo_depth];
   logic [addr_width-1:0]    wr_ptr;
   logic [addr_width-1:0]    rd_ptr;
   logic [count_width-1:0]   count;

   // Word popped last cycle, on its way back to the tail
   logic                     wb_valid;
   logic [pattern_width-1:0] wb_data;

   logic mem_empty;
   logic pop_ok;
   logic pop_wb;
   logic pop_mem;
   logic wr_en;

   function automatic logic [addr_width-1:0] next_ptr(input logic [addr_width-1:0] ptr);
      if (ptr == last_addr) return '0;
      return ptr + 1'b1;
   endfunction

   assign mem_empty = (count == '0);

   // Show-ahead head, a pending write-back covers a one-word pattern
   assign head_valid = !mem_empty || wb_valid;
   assign head_data  = mem_empty ? wb_data : mem[rd_ptr];

   assign pop_ok  = pop && head_valid;
   assign pop_wb  = pop_ok && mem_empty;
   assign pop_mem = pop_ok && !mem_empty;

   // A write-back that is popped again stays in flight
   assign wr_en = load || (wb_valid && !pop_wb);

   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= pop_ok;
         if (wr_en)   wr_ptr <= next_ptr(wr_ptr);
         if (pop_mem) rd_ptr <= next_ptr(rd_ptr);
         if (wr_en && !pop_mem)      count <= count + 1'b1;
         else if (!wr_en && pop_mem) count <= count - 1'b1;
      end
   end

   // Storage and write-back word
   always_ff @(posedge clk) begin
      if (wr_en) mem[wr_ptr] <= wb_valid ? wb_data : load_data;
      if (pop_ok) wb_data <= head_data;
   end

endmodule

`default_nettype wire

/* source/simframe_pkg.sv */
`default_nettype none

package simframe_pkg;

   // ========================================================================
   // Register port widths
   // ========================================================================
   localparam int word_width      = 32;
   localparam int reg_index_width = 5;

   // Bump whenever the register map changes
   localparam logic [word_width-1:0] module_version = 1;

   // ========================================================================
   // Register map
   // ========================================================================
   // Read only
   localparam logic [reg_index_width-1:0] reg_module_rev = 0;
   // Clear requests on write, clear status on read
   localparam logic [reg_index_width-1:0] reg_fifo_ctl   = 1;
   // Immediate loads, read back the word counts
   localparam logic [reg_index_width-1:0] reg_load_f0    = 2;
   localparam logic [reg_index_width-1:0] reg_load_f1    = 3;
   // On-deck select on write, active FIFO on read
   localparam logic [reg_index_width-1:0] reg_start      = 4;
   // Bit 0 set means continuous replay
   localparam logic [reg_index_width-1:0] reg_cont_mode  = 5;

   // Bit positions shared by the control and start registers
   localparam int bit_f0_clear = 0;
   localparam int bit_f1_clear = 1;

   // ========================================================================
   // Response codes
   // ========================================================================
   localparam logic [1:0] resp_okay   = 2'd0;
   localparam logic [1:0] resp_decerr = 2'd3;

   // Cycles that a FIFO is held in clear
   localparam int clear_cycles = 15;

endpackage

`default_nettype wire

/* source/simframe_reg_read.sv */
`timescale 1ns/100ps
`default_nettype none

module simframe_reg_read #(
   parameter int fifo_depth   = 64,
   localparam int count_width = $clog2(fifo_depth + 1)
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic                                       reg_read,
   input  logic [simframe_pkg::reg_index_width-1:0]   reg_rindx,
   input  logic                                       clear_f0,
   input  logic                                       clear_f1,
   input  logic [count_width-1:0]                     f0_count,
   input  logic [count_width-1:0]                     f1_count,
   input  logic [1:0]                                 active_fifo,
   input  logic                                       cont_mode,
   output logic                                       reg_rvalid,
   output logic [simframe_pkg::word_width-1:0]        reg_rdata,
   output logic [1:0]                                 reg_rresp
);

   logic [simframe_pkg::word_width-1:0] rd_value;
   logic [1:0]                          rd_resp;

   // Read-back mux, unused upper bits read as zero
   always_comb begin
      rd_value = '0;
      rd_resp  = simframe_pkg::resp_okay;
      case (reg_rindx)
         simframe_pkg::reg_module_rev: rd_value = simframe_pkg::module_version;
         simframe_pkg::reg_fifo_ctl:   rd_value[1:0] = {clear_f1, clear_f0};
         simframe_pkg::reg_load_f0:    rd_value[count_width-1:0] = f0_count;
         simframe_pkg::reg_load_f1:    rd_value[count_width-1:0] = f1_count;
         simframe_pkg::reg_start:      rd_value[1:0] = active_fifo;
         simframe_pkg::reg_cont_mode:  rd_value[0] = cont_mode;
         default:                      rd_resp = simframe_pkg::resp_decerr;
      endcase
   end

   // Response is one cycle after the strobe
   always_ff @(posedge clk) begin
      if (!resetn) reg_rvalid <= 1'b0;
      else         reg_rvalid <= reg_read;
   end

   always_ff @(posedge clk) begin
      if (reg_read) begin
         reg_rdata <= rd_value;
         reg_rresp <= rd_resp;
      end
   end

endmodule

`default_nettype wire

/* source/simframe_reg_write.sv */
`timescale 1ns/100ps
`default_nettype none

module simframe_reg_write #(
   parameter int pattern_width = 32,
   parameter int fifo_depth    = 64,
   localparam int count_width  = $clog2(fifo_depth + 1)
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic                                       reg_write,
   input  logic [simframe_pkg::reg_index_width-1:0]   reg_windx,
   input  logic [simframe_pkg::word_width-1:0]        reg_wdata,
   input  logic [1:0]                                 active_fifo,
   output logic [1:0]                                 reg_wresp,
   output logic                                       wr_idle,
   output logic                                       load_f0,
   output logic                                       load_f1,
   output logic [pattern_width-1:0]                   load_data,
   output logic                                       clear_f0,
   output logic                                       clear_f1,
   output logic [count_width-1:0]                     f0_count,
   output logic [count_width-1:0]                     f1_count,
   output logic [1:0]                                 on_deck,
   output logic                                       cont_mode,
   output logic                                       new_job
);

   localparam int hold_width = $clog2(simframe_pkg::clear_cycles + 1);
   localparam logic [hold_width-1:0]  hold_start = hold_width'(simframe_pkg::clear_cycles);
   localparam logic [count_width-1:0] count_max  = count_width'(fifo_depth);

   // Nonzero while the matching FIFO is held in clear
   logic [hold_width-1:0] f0_hold;
   logic [hold_width-1:0] f1_hold;

   assign clear_f0 = (f0_hold != '0);
   assign clear_f1 = (f1_hold != '0);

   // No new writes until both hold-offs have run out
   assign wr_idle = (f0_hold == '0) && (f1_hold == '0);

   // ========================================================================
   // Write decode
   // ========================================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         reg_wresp <= simframe_pkg::resp_okay;
         load_f0   <= 1'b0;
         load_f1   <= 1'b0;
         f0_hold   <= '0;
         f1_hold   <= '0;
         f0_count  <= '0;
         f1_count  <= '0;
         on_deck   <= 2'b00;
         cont_mode <= 1'b0;
         new_job   <= 1'b0;
      end else begin
         // Strobes default low
         load_f0 <= 1'b0;
         load_f1 <= 1'b0;
         new_job <= 1'b0;

         // Hold-off counters run down to zero
         if (f0_hold != '0) f0_hold <= f0_hold - 1'b1;
         if (f1_hold != '0) f1_hold <= f1_hold - 1'b1;

         // One-shot pass has claimed the on-deck FIFO
         if ((active_fifo != 2'b00) && !cont_mode) on_deck <= 2'b00;

         if (reg_write) begin
            reg_wresp <= simframe_pkg::resp_okay;
            case (reg_windx)
               // Read only, a write has no effect
               simframe_pkg::reg_module_rev: ;

               simframe_pkg::reg_fifo_ctl: begin
                  // Clears of a streaming FIFO are dropped
                  if (reg_wdata[simframe_pkg::bit_f0_clear] && !active_fifo[0]) begin
                     f0_count <= '0;
                     f0_hold  <= hold_start;
                  end
                  if (reg_wdata[simframe_pkg::bit_f1_clear] && !active_fifo[1]) begin
                     f1_count <= '0;
                     f1_hold  <= hold_start;
                  end
               end

               // Immediate loads, refused while streaming or full
               simframe_pkg::reg_load_f0:
                  if (!active_fifo[0] && (f0_count != count_max)) begin
                     load_f0  <= 1'b1;
                     f0_count <= f0_count + 1'b1;
                  end
               simframe_pkg::reg_load_f1:
                  if (!active_fifo[1] && (f1_count != count_max)) begin
                     load_f1  <= 1'b1;
                     f1_count <= f1_count + 1'b1;
                  end

               simframe_pkg::reg_start:
                  case (reg_wdata[1:0])
                     2'b00: on_deck <= 2'b00;
                     // Empty FIFOs can't be started
                     2'b01:
                        if (f0_count != '0) begin
                           on_deck <= 2'b01;
                           new_job <= (active_fifo == 2'b00);
                        end
                     2'b10:
                        if (f1_count != '0) begin
                           on_deck <= 2'b10;
                           new_job <= (active_fifo == 2'b00);
                        end
                     // Both at once is ignored
                     default: ;
                  endcase

               simframe_pkg::reg_cont_mode: cont_mode <= reg_wdata[0];

               default: reg_wresp <= simframe_pkg::resp_decerr;
            endcase
         end
      end
   end

   // Load word, qualified by the load strobes
   always_ff @(posedge clk) begin
      if (reg_write) load_data <= pattern_width'(reg_wdata);
   end

endmodule

`default_nettype wire

/* source/simframe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module simframe_top #(
   parameter int pattern_width = 32,
   parameter int fifo_depth    = 64,
   localparam int count_width  = $clog2(fifo_depth + 1)
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic                                       reg_write,
   input  logic                                       reg_read,
   input  logic [simframe_pkg::reg_index_width-1:0]   reg_windx,
   input  logic [simframe_pkg::reg_index_width-1:0]   reg_rindx,
   input  logic [simframe_pkg::word_width-1:0]        reg_wdata,
   output logic [1:0]                                 reg_wresp,
   output logic                                       wr_idle,
   output logic                                       reg_rvalid,
   output logic [simframe_pkg::word_width-1:0]        reg_rdata,
   output logic [1:0]                                 reg_rresp,
   output logic [pattern_width-1:0]                   stream_data,
   output logic                                       stream_valid,
   input  logic                                       stream_ready,
   output logic                                       new_job
);

   // Write decode to the FIFOs
   logic                     load_f0;
   logic                     load_f1;
   logic [pattern_width-1:0] load_data;
   logic                     clear_f0;
   logic                     clear_f1;

   // Write decode to the sequencer and read-back
   logic [1:0]               on_deck;
   logic                     cont_mode;
   logic [count_width-1:0]   f0_count;
   logic [count_width-1:0]   f1_count;

   // FIFO heads and pops
   logic [pattern_width-1:0] f0_head;
   logic [pattern_width-1:0] f1_head;
   logic                     f0_head_valid;
   logic                     f1_head_valid;
   logic                     pop_f0;
   logic                     pop_f1;

   logic [1:0]               active_fifo;

   // ========================================================================
   // Decode
   // ========================================================================
   simframe_reg_write #(
      .pattern_width (pattern_width),
      .fifo_depth    (fifo_depth)
   ) u_reg_write (
      .clk         (clk),
      .resetn      (resetn),
      .reg_write   (reg_write),
      .reg_windx   (reg_windx),
      .reg_wdata   (reg_wdata),
      .active_fifo (active_fifo),
      .reg_wresp   (reg_wresp),
      .wr_idle     (wr_idle),
      .load_f0     (load_f0),
      .load_f1     (load_f1),
      .load_data   (load_data),
      .clear_f0    (clear_f0),
      .clear_f1    (clear_f1),
      .f0_count    (f0_count),
      .f1_count    (f1_count),
      .on_deck     (on_deck),
      .cont_mode   (cont_mode),
      .new_job     (new_job)
   );

   // ========================================================================
   // Execute
   // ========================================================================
   pattern_fifo #(
      .pattern_width (pattern_width),
      .fifo_depth    (fifo_depth)
   ) u_fifo0 (
      .clk        (clk),
      .resetn     (resetn),
      .clear      (clear_f0),
      .load       (load_f0),
      .load_data  (load_data),
      .pop        (pop_f0),
      .head_data  (f0_head),
      .head_valid (f0_head_valid)
   );

   pattern_fifo #(
      .pattern_width (pattern_width),
      .fifo_depth    (fifo_depth)
   ) u_fifo1 (
      .clk        (clk),
      .resetn     (resetn),
      .clear      (clear_f1),
      .load       (load_f1),
      .load_data  (load_data),
      .pop        (pop_f1),
      .head_data  (f1_head),
      .head_valid (f1_head_valid)
   );

   stream_sequencer #(
      .pattern_width (pattern_width),
      .fifo_depth    (fifo_depth)
   ) u_sequencer (
      .clk           (clk),
      .resetn        (resetn),
      .on_deck       (on_deck),
      .cont_mode     (cont_mode),
      .f0_count      (f0_count),
      .f1_count      (f1_count),
      .f0_head       (f0_head),
      .f1_head       (f1_head),
      .f0_head_valid (f0_head_valid),
      .f1_head_valid (f1_head_valid),
      .stream_ready  (stream_ready),
      .pop_f0        (pop_f0),
      .pop_f1        (pop_f1),
      .active_fifo   (active_fifo),
      .stream_data   (stream_data),
      .stream_valid  (stream_valid)
   );

   // ========================================================================
   // Result
   // ========================================================================
   simframe_reg_read #(
      .fifo_depth (fifo_depth)
   ) u_reg_read (
      .clk         (clk),
      .resetn      (resetn),
      .reg_read    (reg_read),
      .reg_rindx   (reg_rindx),
      .clear_f0    (clear_f0),
      .clear_f1    (clear_f1),
      .f0_count    (f0_count),
      .f1_count    (f1_count),
      .active_fifo (active_fifo),
      .cont_mode   (cont_mode),
      .reg_rvalid  (reg_rvalid),
      .reg_rdata   (reg_rdata),
      .reg_rresp   (reg_rresp)
   );

endmodule

`default_nettype wire

/* source/stream_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_sequencer #(
   parameter int pattern_width = 32,
   parameter int fifo_depth    = 64,
   localparam int count_width  = $clog2(fifo_depth + 1)
) (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic [1:0]               on_deck,
   input  logic                     cont_mode,
   input  logic [count_width-1:0]   f0_count,
   input  logic [count_width-1:0]   f1_count,
   input  logic [pattern_width-1:0] f0_head,
   input  logic [pattern_width-1:0] f1_head,
   input  logic                     f0_head_valid,
   input  logic                     f1_head_valid,
   input  logic                     stream_ready,
   output logic                     pop_f0,
   output logic                     pop_f1,
   output logic [1:0]               active_fifo,
   output logic [pattern_width-1:0] stream_data,
   output logic                     stream_valid
);

   // Transfers left in the current pass
   logic [count_width-1:0] remaining;

   logic xfer;
   logic pass_done;
   logic chain_ok;
   logic start_f0;
   logic start_f1;

   assign xfer = stream_valid && stream_ready;

   // Last word of this pass is leaving
   assign pass_done = xfer && (remaining == count_width'(1));

   // Only continuous mode chains one pass into the next
   // A one-shot pass always ends idle
   assign chain_ok = !stream_valid || cont_mode;

   // A FIFO can be picked up only with words in it
   assign start_f0 = chain_ok && (on_deck == 2'b01) && (f0_count != '0) && f0_head_valid;
   assign start_f1 = chain_ok && (on_deck == 2'b10) && (f1_count != '0) && f1_head_valid;

   // ========================================================================
   // Output stream
   // ========================================================================
   assign stream_data = active_fifo[1] ? f1_head : f0_head;

   // Each transfer pops the streaming FIFO
   assign pop_f0 = xfer && active_fifo[0];
   assign pop_f1 = xfer && active_fifo[1];

   // ========================================================================
   // Pass sequencing
   // ========================================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         active_fifo  <= 2'b00;
         stream_valid <= 1'b0;
         remaining    <= '0;
      end else if (xfer) begin
         remaining <= remaining - 1'b1;
      end

      // Choose what runs next when idle or when a pass finishes
      if (resetn && (!stream_valid || pass_done)) begin
         if (start_f0) begin
            active_fifo  <= 2'b01;
            remaining    <= f0_count;
            stream_valid <= 1'b1;
         end else if (start_f1) begin
            active_fifo  <= 2'b10;
            remaining    <= f1_count;
            stream_valid <= 1'b1;
         end else begin
            // Nothing runs next
            active_fifo  <= 2'b00;
            stream_valid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
source/simframe_pkg.sv
source/simframe_reg_write.sv
source/pattern_fifo.sv
source/stream_sequencer.sv
source/simframe_reg_read.sv
source/simframe_top.sv
dv/simframe_tb.sv
